/* dv/mont_mult_checker.sv */
`timescale 1ns/1ps

module mont_mult_checker import mont_pkg::*; (
    input  logic                     clk,
    input  logic                     resetn,
    input  logic                     start,
    input  logic                     done,
    input  logic [OPERAND_WIDTH-1:0] result
);

    int unsigned fail_count = 0;

    // set by the first start after reset
    logic started;
    // result on hold between done and the next start
    logic holding;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            started <= 1'b0;
            holding <= 1'b0;
        end else begin
            if (start) begin
                started <= 1'b1;
            end
            if (start) begin
                holding <= 1'b0;
            end else if (done) begin
                holding <= 1'b1;
            end
        end
    end

    done_low_in_reset: assert property (@(posedge clk) !resetn |=> !done)
        else begin
            $error("done not low after a reset cycle");
            fail_count++;
        end

    no_done_before_start: assert property (
        @(posedge clk) disable iff (!resetn) !started |-> !done)
        else begin
            $error("done raised before any start");
            fail_count++;
        end

    done_single_cycle: assert property (
        @(posedge clk) disable iff (!resetn) done |=> !done)
        else begin
            $error("done held high for two cycles");
            fail_count++;
        end

    result_stable_idle: assert property (
        @(posedge clk) disable iff (!resetn) (done || holding) && !start |=> $stable(result))
        else begin
            $error("result changed while idle after done");
            fail_count++;
        end

endmodule

bind mont_mult mont_mult_checker chk0 (
    .clk    (clk),
    .resetn (resetn),
    .start  (start),
    .done   (done),
    .result (result)
);

/* dv/mont_mult_tb.sv */
`timescale 1ns/1ps

module mont_mult_tb import mont_pkg::*; ();

    // start to done, fixed for every operation
    localparam int OP_LATENCY  = 9740;
    // operations with a done pulse
    localparam int NUM_OPS     = 6;
    // the idle watch and the trailing watch count as two more
    localparam int CYCLE_LIMIT = (NUM_OPS + 2) * OP_LATENCY;
    localparam int IDLE_CYCLES = 50;

    logic                     clk;
    logic                     resetn;
    logic                     start;
    logic [OPERAND_WIDTH-1:0] in_a;
    logic [OPERAND_WIDTH-1:0] in_b;
    logic [OPERAND_WIDTH-1:0] in_m;
    logic [OPERAND_WIDTH-1:0] result;
    logic                     done;

    integer seed = 32'h567c;
    int     cycle_count = 0;
    int     done_count = 0;
    int     mismatch_count = 0;

    tb_clock_gen u_clk (
        .clk    (clk),
        .resetn (resetn)
    );

    mont_mult dut0 (
        .clk    (clk),
        .resetn (resetn),
        .start  (start),
        .in_a   (in_a),
        .in_b   (in_b),
        .in_m   (in_m),
        .result (result),
        .done   (done)
    );

    always @(posedge clk) begin
        if (done === 1'b1) begin
            done_count <= done_count + 1;
        end
    end

    // hang guard
    initial begin
        while (cycle_count < CYCLE_LIMIT) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
        $display("** FAIL **");
        $finish;
    end

    // bit-serial Montgomery product, A*B*2^-1024 mod M
    function automatic logic [OPERAND_WIDTH-1:0] mont_model(
        input logic [OPERAND_WIDTH-1:0] a,
        input logic [OPERAND_WIDTH-1:0] b,
        input logic [OPERAND_WIDTH-1:0] m
    );
        logic [OPERAND_WIDTH+2:0] acc;
        acc = '0;
        for (int i = 0; i < OPERAND_WIDTH; i++) begin
            if (a[i]) begin
                acc = acc + b;
            end
            if (acc[0]) begin
                acc = acc + m;
            end
            acc = acc >> 1;
        end
        if (acc >= m) begin
            acc = acc - m;
        end
        return acc[OPERAND_WIDTH-1:0];
    endfunction

    task automatic random_word(output logic [OPERAND_WIDTH-1:0] w);
        for (int i = 0; i < OPERAND_WIDTH / 32; i++) begin
            w[i*32 +: 32] = $random(seed);
        end
    endtask

    // odd modulus with the top bit set
    task automatic random_modulus(output logic [OPERAND_WIDTH-1:0] m);
        random_word(m);
        m[OPERAND_WIDTH-1] = 1'b1;
        m[0] = 1'b1;
    endtask

    // top bit clear keeps the operand below a modulus with top bit set
    task automatic random_operand(output logic [OPERAND_WIDTH-1:0] x);
        random_word(x);
        x[OPERAND_WIDTH-1] = 1'b0;
    endtask

    task automatic wait_done();
        while (done !== 1'b1) begin
            @(negedge clk);
        end
    endtask

    // stray_delay above zero raises a second start that many cycles into the run
    task automatic run_op(
        input string                    name,
        input logic [OPERAND_WIDTH-1:0] a,
        input logic [OPERAND_WIDTH-1:0] b,
        input logic [OPERAND_WIDTH-1:0] m,
        input int                       stray_delay
    );
        logic [OPERAND_WIDTH-1:0] expected;
        logic [OPERAND_WIDTH-1:0] stray;
        int                       done_before;
        expected = mont_model(a, b, m);
        done_before = done_count;
        @(negedge clk);
        in_a  = a;
        in_b  = b;
        in_m  = m;
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
        if (stray_delay > 0) begin
            repeat (stray_delay) @(negedge clk);
            random_word(stray);
            in_a  = stray;
            in_b  = ~stray;
            in_m  = stray | 1;
            start = 1'b1;
            @(negedge clk);
            start = 1'b0;
        end
        wait_done();
        assert (result === expected)
            else begin
                $display("Mismatch in %s: expected %h, actual %h", name, expected, result);
                mismatch_count++;
            end
        // long watch after a stray start and short one otherwise
        if (stray_delay > 0) begin
            repeat (OP_LATENCY + 20) @(negedge clk);
        end else begin
            repeat (4) @(negedge clk);
        end
        assert (done_count == done_before + 1)
            else begin
                $display("Mismatch in %s done pulses: expected 1, actual %0d",
                         name, done_count - done_before);
                mismatch_count++;
            end
    endtask

    initial begin
        logic [OPERAND_WIDTH-1:0] a;
        logic [OPERAND_WIDTH-1:0] b;
        logic [OPERAND_WIDTH-1:0] m;
        int                       total;

        start = 1'b0;
        in_a  = '0;
        in_b  = '0;
        in_m  = '0;

        @(posedge resetn);
        // no start, so no done
        repeat (IDLE_CYCLES) @(negedge clk);
        assert (done_count == 0)
            else begin
                $display("Mismatch in idle_no_start done pulses: expected 0, actual %0d",
                         done_count);
                mismatch_count++;
            end

        run_op("one_times_one", OPERAND_WIDTH'(1), OPERAND_WIDTH'(1),
               OPERAND_WIDTH'(1000003), 0);

        for (int i = 0; i < 3; i++) begin
            random_modulus(m);
            random_operand(a);
            random_operand(b);
            run_op($sformatf("random_%0d", i), a, b, m, 0);
        end

        // all-ones modulus puts the value before reduction at M + 1
        m = '1;
        run_op("m_minus_one", m - 1, m - 1, m, 0);

        random_modulus(m);
        random_operand(a);
        random_operand(b);
        run_op("start_while_busy", a, b, m, 300);

        total = mismatch_count + dut0.chk0.fail_count;
        $display("errors: %0d mismatches, %0d assertion failures",
                 mismatch_count, dut0.chk0.fail_count);
        if (total == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

/* dv/tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk,
    output logic resetn
);

    // 20 ns period
    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // reset held for 8 rising edges, released on a falling edge
    initial begin
        resetn = 1'b0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        resetn = 1'b1;
    end

endmodule

/* project.f */
rtl/mont_pkg.sv
rtl/multiple_table.sv
rtl/operand_select.sv
rtl/adder_slice.sv
rtl/accumulator.sv
rtl/mont_controller.sv
rtl/mont_mult.sv
dv/tb_clock_gen.sv
dv/mont_mult_checker.sv
dv/mont_mult_tb.sv

/* rtl/accumulator.sv */
`timescale 1ns/1ps

module accumulator import mont_pkg::*; (
    input  logic                                   clk,
    input  logic                                   resetn,
    input  logic                                   load,
    input  logic                                   add_commit,
    input  logic                                   shift_en,
    input  logic                                   accept,
    input  logic [NUM_SLICES-1:0][SLICE_WIDTH-1:0] slice_sum,
    output logic [NUM_SLICES-1:0][SLICE_WIDTH-1:0] acc_limbs,
    output digit_t                                 acc_low,
    output logic                                   diff_neg,
    output logic [OPERAND_WIDTH-1:0]               result
);

    logic [ACC_WIDTH-1:0] acc_q;
    logic [ACC_WIDTH-1:0] sum_flat;

    // limbs joined back into one value
    assign sum_flat = slice_sum;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            acc_q <= '0;
        end else if (load) begin
            acc_q <= '0;
        end else if (add_commit) begin
            // rejected trial subtraction leaves the value as is
            if (accept) begin
                acc_q <= sum_flat;
            end
        end else if (shift_en) begin
            // low two bits are zero after the quotient add
            acc_q <= acc_q >> 2;
        end
    end

    assign acc_limbs = acc_q;
    assign acc_low   = acc_q[1:0];

    // sign of the difference during the trial subtraction
    assign diff_neg  = sum_flat[ACC_WIDTH-1];

    // value stays below M after reduction, upper bits are zero
    assign result    = acc_q[OPERAND_WIDTH-1:0];

endmodule

/* rtl/adder_slice.sv */
`timescale 1ns/1ps

module adder_slice import mont_pkg::*; (
    input  logic                   clk,
    input  logic                   resetn,
    input  logic                   en,
    input  logic [SLICE_WIDTH-1:0] a,
    input  logic [SLICE_WIDTH-1:0] b,
    input  logic                   carry_in,
    output logic [SLICE_WIDTH-1:0] sum,
    output logic                   carry_out
);

    // one bit wider to catch the carry
    logic [SLICE_WIDTH:0] total;

    assign total = {1'b0, a} + {1'b0, b} + (SLICE_WIDTH+1)'(carry_in);

    always_ff @(posedge clk) begin
        if (!resetn) begin
            carry_out <= 1'b0;
        end else if (en) begin
            carry_out <= total[SLICE_WIDTH];
        end
    end

    // sum limb held until the next enable
    always_ff @(posedge clk) begin
        if (en) begin
            sum <= total[SLICE_WIDTH-1:0];
        end
    end

endmodule

/* rtl/mont_controller.sv */
`timescale 1ns/1ps

module mont_controller import mont_pkg::*; (
    input  logic                     clk,
    input  logic                     resetn,
    input  logic                     start,
    input  logic [OPERAND_WIDTH-1:0] in_a,
    input  digit_t                   acc_low,
    input  digit_t                   m_low,
    input  logic                     diff_neg,
    output logic                     load,
    output mult_sel_t                sel,
    output logic                     subtract,
    output logic [NUM_SLICES-1:0]    slice_en,
    output logic                     add_commit,
    output logic                     accept,
    output logic                     shift_en,
    output logic                     done
);

    ctrl_state_t state_q;
    ctrl_state_t state_d;

    logic [OPERAND_WIDTH-1:0]   a_q;
    logic [DIGIT_CNT_WIDTH-1:0] digit_cnt;
    logic [STEP_CNT_WIDTH-1:0]  step_cnt;
    logic                       in_add;
    logic                       last_step;
    logic                       last_digit;
    digit_t                     a_digit;
    mult_sel_t                  quot_sel;

    assign in_add     = (state_q == st_add_b) || (state_q == st_add_m)
                        || (state_q == st_reduce);
    assign last_step  = (step_cnt == STEP_CNT_WIDTH'(NUM_SLICES));
    assign last_digit = (digit_cnt == DIGIT_CNT_WIDTH'(NUM_DIGITS - 1));
    assign a_digit    = a_q[1:0];

    // next state
    always_comb begin
        state_d = state_q;
        case (state_q)
            st_idle:   if (start) state_d = st_load;
            st_load:   state_d = st_add_b;
            st_add_b:  if (last_step) state_d = st_add_m;
            st_add_m:  if (last_step) state_d = st_shift;
            st_shift:  state_d = last_digit ? st_reduce : st_add_b;
            st_reduce: if (last_step) state_d = st_finish;
            st_finish: state_d = st_idle;
            default:   state_d = st_idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state_q <= st_idle;
        end else begin
            state_q <= state_d;
        end
    end

    // slice step counter, one extra count for the commit
    always_ff @(posedge clk) begin
        if (!resetn) begin
            step_cnt <= '0;
        end else if (in_add && !last_step) begin
            step_cnt <= step_cnt + 1'b1;
        end else begin
            step_cnt <= '0;
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            digit_cnt <= '0;
        end else if (load) begin
            digit_cnt <= '0;
        end else if (state_q == st_shift) begin
            digit_cnt <= digit_cnt + 1'b1;
        end
    end

    // A drops one radix-4 digit per shift
    always_ff @(posedge clk) begin
        if (load) begin
            a_q <= in_a;
        end else if (state_q == st_shift) begin
            a_q <= a_q >> 2;
        end
    end

    // quotient digit that clears the low two bits, m_low is 1 or 3
    always_comb begin
        if (acc_low[0] && (acc_low == m_low)) begin
            quot_sel = sel_m3;
        end else if (acc_low == 2'd2) begin
            quot_sel = sel_m2;
        end else if (acc_low[0]) begin
            quot_sel = sel_m1;
        end else begin
            quot_sel = sel_zero;
        end
    end

    always_comb begin
        case (state_q)
            st_add_b: begin
                case (a_digit)
                    2'd1:    sel = sel_b1;
                    2'd2:    sel = sel_b2;
                    2'd3:    sel = sel_b3;
                    default: sel = sel_zero;
                endcase
            end
            st_add_m:  sel = quot_sel;
            st_reduce: sel = sel_m1;
            default:   sel = sel_zero;
        endcase
    end

    // start is only taken while idle
    assign load       = (state_q == st_idle) && start;
    assign subtract   = (state_q == st_reduce);
    assign slice_en   = (in_add && !last_step) ? (NUM_SLICES'(1) << step_cnt) : '0;
    assign add_commit = in_add && last_step;
    assign accept     = (state_q != st_reduce) || !diff_neg;
    assign shift_en   = (state_q == st_shift);

    always_ff @(posedge clk) begin
        if (!resetn) begin
            done <= 1'b0;
        end else begin
            done <= (state_q == st_finish);
        end
    end

endmodule

/* rtl/mont_mult.sv */
`timescale 1ns/1ps

module mont_mult import mont_pkg::*; (
    input  logic                     clk,
    input  logic                     resetn,
    input  logic                     start,
    input  logic [OPERAND_WIDTH-1:0] in_a,
    input  logic [OPERAND_WIDTH-1:0] in_b,
    input  logic [OPERAND_WIDTH-1:0] in_m,
    output logic [OPERAND_WIDTH-1:0] result,
    output logic                     done
);

    logic                                   load;
    mult_sel_t                              sel;
    logic                                   subtract;
    logic [NUM_SLICES-1:0]                  slice_en;
    logic                                   add_commit;
    logic                                   accept;
    logic                                   shift_en;
    logic [ACC_WIDTH-1:0]                   multiple;
    digit_t                                 m_low;
    digit_t                                 acc_low;
    logic                                   diff_neg;
    logic [NUM_SLICES-1:0][SLICE_WIDTH-1:0] limb_b;
    logic [NUM_SLICES-1:0][SLICE_WIDTH-1:0] acc_limbs;
    logic [NUM_SLICES-1:0][SLICE_WIDTH-1:0] slice_sum;
    // carry[i] enters slice i
    logic [NUM_SLICES:0]                    carry;

    multiple_table u_table (
        .clk      (clk),
        .resetn   (resetn),
        .load     (load),
        .in_b     (in_b),
        .in_m     (in_m),
        .sel      (sel),
        .multiple (multiple),
        .m_low    (m_low)
    );

    operand_select u_select (
        .multiple (multiple),
        .subtract (subtract),
        .limb_b   (limb_b)
    );

    assign carry[0] = subtract;

    for (genvar i = 0; i < NUM_SLICES; i++) begin : g_slice
        adder_slice u_slice (
            .clk       (clk),
            .resetn    (resetn),
            .en        (slice_en[i]),
            .a         (acc_limbs[i]),
            .b         (limb_b[i]),
            .carry_in  (carry[i]),
            .sum       (slice_sum[i]),
            .carry_out (carry[i+1])
        );
    end

    accumulator u_acc (
        .clk        (clk),
        .resetn     (resetn),
        .load       (load),
        .add_commit (add_commit),
        .shift_en   (shift_en),
        .accept     (accept),
        .slice_sum  (slice_sum),
        .acc_limbs  (acc_limbs),
        .acc_low    (acc_low),
        .diff_neg   (diff_neg),
        .result     (result)
    );

    mont_controller u_ctrl (
        .clk        (clk),
        .resetn     (resetn),
        .start      (start),
        .in_a       (in_a),
        .acc_low    (acc_low),
        .m_low      (m_low),
        .diff_neg   (diff_neg),
        .load       (load),
        .sel        (sel),
        .subtract   (subtract),
        .slice_en   (slice_en),
        .add_commit (add_commit),
        .accept     (accept),
        .shift_en   (shift_en),
        .done       (done)
    );

endmodule

/* rtl/mont_pkg.sv */
package mont_pkg;

    // operand and datapath widths
    localparam int OPERAND_WIDTH = 1024;
    // headroom for 3M plus the running sum and a sign bit
    localparam int ACC_WIDTH     = 1032;
    localparam int NUM_SLICES    = 8;
    localparam int SLICE_WIDTH   = ACC_WIDTH / NUM_SLICES;

    // radix-4 scan of A
    localparam int NUM_DIGITS    = OPERAND_WIDTH / 2;

    // counter widths for the controller
    localparam int DIGIT_CNT_WIDTH = $clog2(NUM_DIGITS);
    // one extra count for the commit cycle
    localparam int STEP_CNT_WIDTH  = $clog2(NUM_SLICES + 1);

    typedef logic [1:0] digit_t;

    // which precomputed multiple feeds the adder
    typedef enum logic [2:0] {
        sel_zero,
        sel_b1,
        sel_b2,
        sel_b3,
        sel_m1,
        sel_m2,
        sel_m3
    } mult_sel_t;

    typedef enum logic [2:0] {
        st_idle,
        st_load,
        st_add_b,
        st_add_m,
        st_shift,
        st_reduce,
        st_finish
    } ctrl_state_t;

endpackage

/* rtl/multiple_table.sv */
`timescale 1ns/1ps

module multiple_table import mont_pkg::*; (
    input  logic                     clk,
    input  logic                     resetn,
    input  logic                     load,
    input  logic [OPERAND_WIDTH-1:0] in_b,
    input  logic [OPERAND_WIDTH-1:0] in_m,
    input  mult_sel_t                sel,
    output logic [ACC_WIDTH-1:0]     multiple,
    output digit_t                   m_low
);

    logic [ACC_WIDTH-1:0] b_ext;
    logic [ACC_WIDTH-1:0] m_ext;
    logic [ACC_WIDTH-1:0] b_x3;
    logic [ACC_WIDTH-1:0] m_x3;

    logic [ACC_WIDTH-1:0] b1_q, b2_q, b3_q;
    logic [ACC_WIDTH-1:0] m1_q, m2_q, m3_q;

    assign b_ext = ACC_WIDTH'(in_b);
    assign m_ext = ACC_WIDTH'(in_m);

    // triples formed as x + 2x
    assign b_x3 = b_ext + (b_ext << 1);
    assign m_x3 = m_ext + (m_ext << 1);

    always_ff @(posedge clk) begin
        if (!resetn) begin
            b1_q <= '0;
            b2_q <= '0;
            b3_q <= '0;
            m1_q <= '0;
            m2_q <= '0;
            m3_q <= '0;
        end else if (load) begin
            b1_q <= b_ext;
            b2_q <= b_ext << 1;
            b3_q <= b_x3;
            m1_q <= m_ext;
            m2_q <= m_ext << 1;
            m3_q <= m_x3;
        end
    end

    always_comb begin
        case (sel)
            sel_b1:  multiple = b1_q;
            sel_b2:  multiple = b2_q;
            sel_b3:  multiple = b3_q;
            sel_m1:  multiple = m1_q;
            sel_m2:  multiple = m2_q;
            sel_m3:  multiple = m3_q;
            default: multiple = '0;
        endcase
    end

    // modulus is odd, so this is 1 or 3
    assign m_low = m1_q[1:0];

endmodule

/* rtl/operand_select.sv */
`timescale 1ns/1ps

module operand_select import mont_pkg::*; (
    input  logic [ACC_WIDTH-1:0]                      multiple,
    input  logic                                      subtract,
    output logic [NUM_SLICES-1:0][SLICE_WIDTH-1:0]    limb_b
);

    logic [ACC_WIDTH-1:0] operand;

    // ones complement here, the +1 comes in as carry into slice 0
    assign operand = subtract ? ~multiple : multiple;

    // cut into limbs, limb 0 holds the least significant bits
    always_comb begin
        for (int i = 0; i < NUM_SLICES; i++) begin
            limb_b[i] = operand[i*SLICE_WIDTH +: SLICE_WIDTH];
        end
    end

endmodule
